/* Makefile */
# Verilator build and run of the peripheral subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_periph_subsystem
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

# The simulator exits non-zero when the testbench fails
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* ahbl_to_apb/ahbl_to_apb.sv */
`timescale 1ns/10ps
`include "periph_defines.svh"

module ahbl_to_apb (
	input  logic                   clk,
	input  logic                   reset,

	input  periph_pkg::ahbl_req_t  ahb_req,
	input  logic [`W_DATA-1:0]     hwdata,
	input  logic                   hready,
	output logic                   hready_resp,
	output logic                   hresp,
	output logic [`W_DATA-1:0]     hrdata,

	output periph_pkg::apb_req_t   apb_req,
	input  periph_pkg::apb_resp_t  apb_resp
);

typedef enum logic [2:0] {
	s_idle,
	s_setup,
	s_access,
	s_error1, // hresp high, hready_resp low
	s_error2  // hresp high, hready_resp high
} state_t;

state_t              state;
state_t              state_nxt;
logic [`W_PADDR-1:0] addr_q;
logic                write_q;
logic                take_xfer;

// ========================================
// Address phase capture
// ========================================

// A new transfer may start while the previous one finishes (idle or
// the last error cycle), which is exactly when hready_resp is high
assign take_xfer = hready && ahb_req.htrans == `HTRANS_NONSEQ
	&& (state == s_idle || state == s_error2);

always_ff @(posedge clk) begin
	if (take_xfer) begin
		addr_q  <= ahb_req.haddr[`W_PADDR-1:0]; // Splitter only needs the low bits
		write_q <= ahb_req.hwrite;
	end
end

// ========================================
// State machine
// ========================================

always_comb begin
	state_nxt = state;
	case (state)
		s_idle, s_error2: state_nxt = take_xfer ? s_setup : s_idle;
		s_setup:          state_nxt = s_access;
		s_access: begin
			if (apb_resp.pready)
				state_nxt = apb_resp.pslverr ? s_error1 : s_idle;
		end
		s_error1:         state_nxt = s_error2;
		default:          state_nxt = s_idle;
	endcase
end

always_ff @(posedge clk) begin
	if (reset)
		state <= s_idle;
	else
		state <= state_nxt;
end

// Read data is held for the cycle after access, when hready_resp goes high
always_ff @(posedge clk) begin
	if (state == s_access && apb_resp.pready)
		hrdata <= apb_resp.prdata;
end

// ========================================
// Outputs
// ========================================

assign hready_resp = state == s_idle || state == s_error2;
assign hresp       = state == s_error1 || state == s_error2;

assign apb_req.paddr   = addr_q;
assign apb_req.psel    = state == s_setup || state == s_access;
assign apb_req.penable = state == s_access;
assign apb_req.pwrite  = write_q;
assign apb_req.pwdata  = hwdata; // Master holds hwdata until hready_resp

// ========================================
// Assertions
// ========================================

penable_needs_psel: assert property (@(posedge clk) disable iff (reset)
	apb_req.penable |-> apb_req.psel);

// Two-cycle error response, never longer
hresp_two_cycles: assert property (@(posedge clk) disable iff (reset)
	$rose(hresp) |-> ##1 hresp ##1 !hresp);

endmodule

/* common/periph_defines.svh */
`ifndef PERIPH_DEFINES_SVH
`define PERIPH_DEFINES_SVH

// ========================================
// Bus widths
// ========================================
`define W_HADDR       32
`define W_PADDR       16
`define W_DATA        32
`define N_PADS        8

`define HTRANS_IDLE   2'b00
`define HTRANS_NONSEQ 2'b10

// ========================================
// Address map
// ========================================
`define AHB_BASE_APB  32'h4000_0000 // Start of APB window on AHB
`define APB_SLOT_GPIO 4'h0          // paddr[15:12]
`define APB_SLOT_PWM  4'h1

// Offsets within a slot, compared against paddr[11:0]
`define REG_GPIO_OUT  12'h000
`define REG_GPIO_OE   12'h004
`define REG_GPIO_IN   12'h008
`define REG_GPIO_FSEL 12'h00c
`define REG_PWM_CTRL  12'h000
`define REG_PWM_CC    12'h004

`endif

/* common/periph_pkg.sv */
`include "periph_defines.svh"

package periph_pkg;

	// ========================================
	// AHB-Lite
	// ========================================

	// Address phase only, hwdata travels separately in the data phase
	typedef struct packed {
		logic [`W_HADDR-1:0] haddr;
		logic                hwrite;
		logic [1:0]          htrans;
		logic [2:0]          hsize;
	} ahbl_req_t;

	// ========================================
	// APB
	// ========================================

	// Master to slave
	typedef struct packed {
		logic [`W_PADDR-1:0] paddr;
		logic                psel;
		logic                penable;
		logic                pwrite;
		logic [`W_DATA-1:0]  pwdata;
	} apb_req_t;

	// Slave to master, pslverr only meaningful with pready
	typedef struct packed {
		logic [`W_DATA-1:0] prdata;
		logic               pready;
		logic               pslverr;
	} apb_resp_t;

endpackage

/* dv/tb_periph_subsystem.sv */
`timescale 1ns/10ps
`include "periph_defines.svh"

module tb_periph_subsystem;

import periph_pkg::*;

localparam int clk_period = 100;
localparam int pwm_div    = 3;
localparam int n_rand     = 8;
localparam logic [3:0] slot_unmapped = 4'h5;
// Transfers take about five cycles each, plus the PWM windows
localparam int test_cycles = 4 + 80 * 5 + 256 * (1 + pwm_div) + 64;

logic                clk;
logic                reset;
ahbl_req_t           ahb_req;
logic [`W_DATA-1:0]  hwdata;
logic                hready;
logic                hready_resp;
logic                hresp;
logic [`W_DATA-1:0]  hrdata;
logic [`N_PADS-1:0]  padout;
logic [`N_PADS-1:0]  padoe;
logic [`N_PADS-1:0]  padin;

// Reference model of the register contents
logic [`N_PADS-1:0]  m_out;
logic [`N_PADS-1:0]  m_oe;
logic [`N_PADS-1:0]  m_fsel;
logic [`N_PADS-1:0]  m_in;
logic                m_pwm_en;
logic [7:0]          m_pwm_div;
logic [7:0]          m_pwm_cc;
logic                monitor_on;
logic [31:0]         rng;

assign hready = hready_resp; // Single slave, master follows the slave

periph_subsystem uut (
	.clk         (clk),
	.reset       (reset),
	.ahb_req     (ahb_req),
	.hwdata      (hwdata),
	.hready      (hready),
	.hready_resp (hready_resp),
	.hresp       (hresp),
	.hrdata      (hrdata),
	.padout      (padout),
	.padoe       (padoe),
	.padin       (padin)
);

initial clk = 1'b0;
always #(clk_period / 2) clk = ~clk;

// ========================================
// Reference functions
// ========================================

function automatic logic [31:0] xorshift32(input logic [31:0] x);
	logic [31:0] s;
	s = x;
	s = s ^ (s << 13);
	s = s ^ (s >> 17);
	s = s ^ (s << 5);
	return s;
endfunction

function automatic logic [31:0] apb_addr(input logic [3:0] slot, input logic [11:0] offset);
	return `AHB_BASE_APB | {16'h0, slot, offset};
endfunction

function automatic logic [31:0] pads32(input logic [`N_PADS-1:0] p);
	return {{(`W_DATA - `N_PADS){1'b0}}, p};
endfunction

function automatic logic [31:0] gpio_read_expect(input logic [11:0] offset);
	case (offset)
		`REG_GPIO_OUT:  return pads32(m_out);
		`REG_GPIO_OE:   return pads32(m_oe);
		`REG_GPIO_IN:   return pads32(m_in);
		`REG_GPIO_FSEL: return pads32(m_fsel);
		default:        return 32'h0;
	endcase
endfunction

function automatic logic [31:0] pwm_read_expect(input logic [11:0] offset);
	case (offset)
		`REG_PWM_CTRL: return {16'h0, m_pwm_div, 7'h0, m_pwm_en};
		`REG_PWM_CC:   return {24'h0, m_pwm_cc};
		default:       return 32'h0;
	endcase
endfunction

// Each pad picks the PWM level when its function is selected
function automatic logic [`N_PADS-1:0] pad_out_expect(input logic [`N_PADS-1:0] out,
		input logic [`N_PADS-1:0] fsel, input logic pwm);
	logic [`N_PADS-1:0] p;
	for (int i = 0; i < `N_PADS; i++)
		p[i] = fsel[i] ? pwm : out[i];
	return p;
endfunction

function automatic logic [`N_PADS-1:0] pad_oe_expect(input logic [`N_PADS-1:0] oe,
		input logic [`N_PADS-1:0] fsel);
	logic [`N_PADS-1:0] e;
	for (int i = 0; i < `N_PADS; i++)
		e[i] = fsel[i] ? 1'b1 : oe[i];
	return e;
endfunction

// Divisor 0 counts as 1
function automatic int pwm_window(input logic [7:0] d);
	return (d == 8'd0) ? 256 : 256 * int'(d);
endfunction

function automatic int pwm_high_expect(input logic [7:0] c, input logic [7:0] d);
	return int'(c) * ((d == 8'd0) ? 1 : int'(d));
endfunction

// ========================================
// Checks and bus tasks
// ========================================

task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
	if (actual !== expected) begin
		$display("Error at %0d ns: %s: got %h, expected %h", $time, what, actual, expected);
		$display("TESTBENCH FAILED");
		$fatal(1, "Mismatch in %s", what);
	end
endtask

// Called 1 ns after a rising edge while the bridge is ready
task automatic ahb_transfer(input logic [31:0] addr, input logic write,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
	ahb_req.haddr  = addr;
	ahb_req.hwrite = write;
	ahb_req.htrans = `HTRANS_NONSEQ;
	ahb_req.hsize  = 3'b010; // Word
	@(posedge clk);
	#1;
	ahb_req.htrans = `HTRANS_IDLE;
	hwdata = wdata; // Data phase
	while (!hready_resp) begin
		@(posedge clk);
		#1;
	end
	rdata = hrdata;
	err   = hresp;
endtask

task automatic ahb_write(input logic [31:0] addr, input logic [31:0] data, output logic err);
	logic [31:0] unused_rdata;
	ahb_transfer(addr, 1'b1, data, unused_rdata, err);
endtask

task automatic ahb_read(input logic [31:0] addr, output logic [31:0] rdata, output logic err);
	ahb_transfer(addr, 1'b0, 32'h0, rdata, err);
endtask

task automatic reg_readback(input logic [31:0] addr, input logic [31:0] expected,
		input string what);
	logic [31:0] rdata;
	logic        err;
	ahb_read(addr, rdata, err);
	check_value({31'b0, err}, 32'd0, {what, " hresp"});
	check_value(rdata, expected, what);
endtask

task automatic gpio_write(input logic [11:0] offset, input logic [31:0] data);
	logic err;
	ahb_write(apb_addr(`APB_SLOT_GPIO, offset), data, err);
	check_value({31'b0, err}, 32'd0, "hresp on GPIO write");
	case (offset)
		`REG_GPIO_OUT:  m_out  = data[`N_PADS-1:0];
		`REG_GPIO_OE:   m_oe   = data[`N_PADS-1:0];
		`REG_GPIO_FSEL: m_fsel = data[`N_PADS-1:0];
		default: ; // IN is read-only
	endcase
endtask

task automatic pwm_write(input logic [11:0] offset, input logic [31:0] data);
	logic err;
	ahb_write(apb_addr(`APB_SLOT_PWM, offset), data, err);
	check_value({31'b0, err}, 32'd0, "hresp on PWM write");
	case (offset)
		`REG_PWM_CTRL: begin
			m_pwm_en  = data[0];
			m_pwm_div = data[15:8];
		end
		`REG_PWM_CC: m_pwm_cc = data[7:0];
		default: ;
	endcase
endtask

// Counts the cycles with pad 0 high, ends 1 ns after a rising edge
task automatic count_pad_high(input int n, output int high);
	high = 0;
	repeat (n) begin
		@(negedge clk);
		if (padout[0])
			high++;
	end
	@(posedge clk);
	#1;
endtask

// Pads without the PWM function follow the model at all times
always @(negedge clk) begin
	if (monitor_on) begin
		check_value(pads32(padout & ~m_fsel), pads32(m_out & ~m_fsel), "padout on GPIO pads");
		check_value(pads32(padoe), pads32(pad_oe_expect(m_oe, m_fsel)), "padoe");
	end
end

// ========================================
// Test sequence
// ========================================

initial begin
	logic [31:0] rdata;
	logic        err;
	logic [7:0]  c;
	int          high;

	reset      = 1'b1;
	ahb_req    = '0;
	hwdata     = '0;
	padin      = '0;
	rng        = 32'h0af4_3db3;
	monitor_on = 1'b0;
	m_out      = '0;
	m_oe       = '0;
	m_fsel     = '0;
	m_in       = '0;
	m_pwm_en   = 1'b0;
	m_pwm_div  = 8'd0;
	m_pwm_cc   = 8'd0;
	repeat (4) @(posedge clk);
	#1;
	reset = 1'b0;

	// State after reset
	check_value(pads32(padout), 32'h0, "padout after reset");
	check_value(pads32(padoe), 32'h0, "padoe after reset");
	reg_readback(apb_addr(`APB_SLOT_GPIO, `REG_GPIO_OUT), gpio_read_expect(`REG_GPIO_OUT),
		"GPIO OUT after reset");
	reg_readback(apb_addr(`APB_SLOT_GPIO, `REG_GPIO_OE), gpio_read_expect(`REG_GPIO_OE),
		"GPIO OE after reset");
	reg_readback(apb_addr(`APB_SLOT_GPIO, `REG_GPIO_FSEL), gpio_read_expect(`REG_GPIO_FSEL),
		"GPIO FSEL after reset");
	monitor_on = 1'b1;

	// Random OUT and OE
	for (int i = 0; i < n_rand; i++) begin
		rng = xorshift32(rng);
		gpio_write(`REG_GPIO_OUT, rng);
		rng = xorshift32(rng);
		gpio_write(`REG_GPIO_OE, rng);
		reg_readback(apb_addr(`APB_SLOT_GPIO, `REG_GPIO_OUT), gpio_read_expect(`REG_GPIO_OUT),
			"GPIO OUT readback");
		reg_readback(apb_addr(`APB_SLOT_GPIO, `REG_GPIO_OE), gpio_read_expect(`REG_GPIO_OE),
			"GPIO OE readback");
	end

	// PWM still disabled, so selected pads drive low
	rng = xorshift32(rng);
	gpio_write(`REG_GPIO_FSEL, rng);
	reg_readback(apb_addr(`APB_SLOT_GPIO, `REG_GPIO_FSEL), gpio_read_expect(`REG_GPIO_FSEL),
		"GPIO FSEL readback");
	check_value(pads32(padout), pads32(pad_out_expect(m_out, m_fsel, 1'b0)),
		"padout with idle PWM");
	gpio_write(`REG_GPIO_FSEL, 32'h0);

	// Input synchroniser
	rng   = xorshift32(rng);
	padin = rng[`N_PADS-1:0];
	m_in  = rng[`N_PADS-1:0];
	repeat (2) @(posedge clk);
	#1;
	reg_readback(apb_addr(`APB_SLOT_GPIO, `REG_GPIO_IN), gpio_read_expect(`REG_GPIO_IN),
		"GPIO IN after padin change");
	gpio_write(`REG_GPIO_IN, ~rng);
	reg_readback(apb_addr(`APB_SLOT_GPIO, `REG_GPIO_IN), gpio_read_expect(`REG_GPIO_IN),
		"GPIO IN after write");

	// ========================================
	// PWM on pad 0
	// ========================================
	gpio_write(`REG_GPIO_OE, 32'h0); // Pad 0 enable then comes from FSEL alone
	rng = xorshift32(rng);
	c   = rng[7:0];
	pwm_write(`REG_PWM_CC, {24'h0, c});
	gpio_write(`REG_GPIO_FSEL, 32'h1);
	pwm_write(`REG_PWM_CTRL, 32'h0000_0001); // Divisor 0
	count_pad_high(pwm_window(m_pwm_div), high);
	check_value(high, pwm_high_expect(m_pwm_cc, m_pwm_div), "PWM high cycles, divisor 0");
	check_value({31'b0, padoe[0]}, 32'd1, "padoe bit 0 with PWM function");

	rng = xorshift32(rng);
	c   = rng[7:0];
	pwm_write(`REG_PWM_CC, {24'h0, c});
	pwm_write(`REG_PWM_CTRL, {16'h0, 8'(pwm_div), 8'h01});
	count_pad_high(pwm_window(m_pwm_div), high);
	check_value(high, pwm_high_expect(m_pwm_cc, m_pwm_div), "PWM high cycles with divisor");
	check_value({31'b0, padoe[0]}, 32'd1, "padoe bit 0 with PWM function");

	pwm_write(`REG_PWM_CTRL, {16'h0, 8'(pwm_div), 8'h00});
	count_pad_high(64, high);
	check_value(high, 32'd0, "pad 0 with PWM disabled");

	// Unmapped slot
	ahb_read(apb_addr(slot_unmapped, 12'h000), rdata, err);
	check_value({31'b0, err}, 32'd1, "hresp on unmapped read");
	rng = xorshift32(rng);
	ahb_write(apb_addr(slot_unmapped, 12'h000), rng, err);
	check_value({31'b0, err}, 32'd1, "hresp on unmapped write");
	rng = xorshift32(rng);
	ahb_write(apb_addr(slot_unmapped, 12'h004), rng, err);
	check_value({31'b0, err}, 32'd1, "hresp on unmapped write");
	reg_readback(apb_addr(`APB_SLOT_GPIO, `REG_GPIO_OUT), gpio_read_expect(`REG_GPIO_OUT),
		"GPIO OUT after unmapped access");
	reg_readback(apb_addr(`APB_SLOT_GPIO, `REG_GPIO_OE), gpio_read_expect(`REG_GPIO_OE),
		"GPIO OE after unmapped access");
	reg_readback(apb_addr(`APB_SLOT_GPIO, `REG_GPIO_FSEL), gpio_read_expect(`REG_GPIO_FSEL),
		"GPIO FSEL after unmapped access");
	reg_readback(apb_addr(`APB_SLOT_PWM, `REG_PWM_CTRL), pwm_read_expect(`REG_PWM_CTRL),
		"PWM CTRL after unmapped access");
	reg_readback(apb_addr(`APB_SLOT_PWM, `REG_PWM_CC), pwm_read_expect(`REG_PWM_CC),
		"PWM CC after unmapped access");

	$display("TESTBENCH PASSED");
	$finish;
end

// Watchdog
initial begin
	#(20 * test_cycles * clk_period);
	$display("Timeout: the tests did not finish within %0d cycles", 20 * test_cycles);
	$display("TESTBENCH FAILED");
	$fatal(1, "Watchdog expired");
end

endmodule

/* sim.f */
+incdir+common
common/periph_pkg.sv
ahbl_to_apb/ahbl_to_apb.sv
source/apb_splitter.sv
source/pwm_tiny.sv
source/gpio.sv
source/periph_subsystem.sv
dv/tb_periph_subsystem.sv

/* source/apb_splitter.sv */
`timescale 1ns/10ps
`include "periph_defines.svh"

module apb_splitter (
	input  periph_pkg::apb_req_t  apb_req,
	output periph_pkg::apb_resp_t apb_resp,

	output periph_pkg::apb_req_t  gpio_req,
	input  periph_pkg::apb_resp_t gpio_resp,

	output periph_pkg::apb_req_t  pwm_req,
	input  periph_pkg::apb_resp_t pwm_resp
);

import periph_pkg::*;

// Answer for a slot with nothing behind it
localparam apb_resp_t resp_unmapped = '{
	prdata:  '0,
	pready:  1'b1,
	pslverr: 1'b1
};

logic [3:0] slot;
logic       sel_gpio;
logic       sel_pwm;

assign slot     = apb_req.paddr[15:12];
assign sel_gpio = slot == `APB_SLOT_GPIO;
assign sel_pwm  = slot == `APB_SLOT_PWM;

// Slaves see the full request, only psel is steered
always_comb begin
	gpio_req      = apb_req;
	gpio_req.psel = apb_req.psel && sel_gpio;
	pwm_req       = apb_req;
	pwm_req.psel  = apb_req.psel && sel_pwm;
end

always_comb begin
	if (sel_gpio)
		apb_resp = gpio_resp;
	else if (sel_pwm)
		apb_resp = pwm_resp;
	else
		apb_resp = resp_unmapped;
end

always_comb begin
	assert (!(gpio_req.psel && pwm_req.psel))
		else $error("apb_splitter: more than one slave selected");
end

endmodule

/* source/gpio.sv */
`timescale 1ns/10ps
`include "periph_defines.svh"

module gpio (
	input  logic                  clk,
	input  logic                  reset,

	input  periph_pkg::apb_req_t  apb_req,
	output periph_pkg::apb_resp_t apb_resp,

	input  logic                  pwm_in,

	output logic [`N_PADS-1:0]    padout,
	output logic [`N_PADS-1:0]    padoe,
	input  logic [`N_PADS-1:0]    padin
);

localparam int w_pad_ext = `W_DATA - `N_PADS; // Zero bits above the pads on reads

logic [`N_PADS-1:0] reg_out;
logic [`N_PADS-1:0] reg_oe;
logic [`N_PADS-1:0] reg_fsel; // 1 selects the PWM function on that pad
logic [`N_PADS-1:0] in_meta;
logic [`N_PADS-1:0] in_sync;
logic [`N_PADS-1:0] rdata;
logic               apb_write;

assign apb_write = apb_req.psel && apb_req.penable && apb_req.pwrite;

// ========================================
// Registers
// ========================================

always_ff @(posedge clk) begin
	if (reset) begin
		reg_out  <= '0;
		reg_oe   <= '0;
		reg_fsel <= '0;
	end else if (apb_write) begin
		case (apb_req.paddr[11:0])
			`REG_GPIO_OUT:  reg_out  <= apb_req.pwdata[`N_PADS-1:0];
			`REG_GPIO_OE:   reg_oe   <= apb_req.pwdata[`N_PADS-1:0];
			`REG_GPIO_FSEL: reg_fsel <= apb_req.pwdata[`N_PADS-1:0];
			default: ; // IN is read-only
		endcase
	end
end

// Pads are asynchronous to clk
always_ff @(posedge clk) begin
	in_meta <= padin;
	in_sync <= in_meta;
end

always_comb begin
	case (apb_req.paddr[11:0])
		`REG_GPIO_OUT:  rdata = reg_out;
		`REG_GPIO_OE:   rdata = reg_oe;
		`REG_GPIO_IN:   rdata = in_sync;
		`REG_GPIO_FSEL: rdata = reg_fsel;
		default:        rdata = '0;
	endcase
end

assign apb_resp.prdata  = {{w_pad_ext{1'b0}}, rdata};
assign apb_resp.pready  = 1'b1;
assign apb_resp.pslverr = 1'b0;

// ========================================
// Pad mux
// ========================================

// PWM function forces the pad to drive
assign padout = (reg_fsel & {`N_PADS{pwm_in}}) | (~reg_fsel & reg_out);
assign padoe  = reg_fsel | reg_oe;

endmodule

/* source/periph_subsystem.sv */
`timescale 1ns/10ps
`include "periph_defines.svh"

module periph_subsystem (
	input  logic                  clk,
	input  logic                  reset,

	input  periph_pkg::ahbl_req_t ahb_req,
	input  logic [`W_DATA-1:0]    hwdata,
	input  logic                  hready,
	output logic                  hready_resp,
	output logic                  hresp,
	output logic [`W_DATA-1:0]    hrdata,

	output logic [`N_PADS-1:0]    padout,
	output logic [`N_PADS-1:0]    padoe,
	input  logic [`N_PADS-1:0]    padin
);

import periph_pkg::*;

apb_req_t  bridge_req;
apb_resp_t bridge_resp;
apb_req_t  gpio_req;
apb_resp_t gpio_resp;
apb_req_t  pwm_req;
apb_resp_t pwm_resp;
logic      pwm_out;

ahbl_to_apb inst_ahbl_to_apb (
	.clk         (clk),
	.reset       (reset),
	.ahb_req     (ahb_req),
	.hwdata      (hwdata),
	.hready      (hready),
	.hready_resp (hready_resp),
	.hresp       (hresp),
	.hrdata      (hrdata),
	.apb_req     (bridge_req),
	.apb_resp    (bridge_resp)
);

apb_splitter inst_apb_splitter (
	.apb_req   (bridge_req),
	.apb_resp  (bridge_resp),
	.gpio_req  (gpio_req),
	.gpio_resp (gpio_resp),
	.pwm_req   (pwm_req),
	.pwm_resp  (pwm_resp)
);

pwm_tiny inst_pwm_tiny (
	.clk      (clk),
	.reset    (reset),
	.apb_req  (pwm_req),
	.apb_resp (pwm_resp),
	.pwm_out  (pwm_out) // Only reaches the outside world through the GPIO mux
);

gpio inst_gpio (
	.clk      (clk),
	.reset    (reset),
	.apb_req  (gpio_req),
	.apb_resp (gpio_resp),
	.pwm_in   (pwm_out),
	.padout   (padout),
	.padoe    (padoe),
	.padin    (padin)
);

endmodule

/* source/pwm_tiny.sv */
`timescale 1ns/10ps
`include "periph_defines.svh"

module pwm_tiny (
	input  logic                  clk,
	input  logic                  reset,

	input  periph_pkg::apb_req_t  apb_req,
	output periph_pkg::apb_resp_t apb_resp,

	output logic                  pwm_out
);

logic       en;
logic [7:0] div;   // Prescale divisor, 0 behaves as 1
logic [7:0] cc;
logic [7:0] presc;
logic [7:0] ctr;
logic [7:0] div_m1;
logic       presc_wrap;
logic       apb_write;

assign apb_write = apb_req.psel && apb_req.penable && apb_req.pwrite;

// ========================================
// Registers
// ========================================

always_ff @(posedge clk) begin
	if (reset) begin
		en  <= 1'b0;
		div <= 8'd0;
		cc  <= 8'd0;
	end else if (apb_write) begin
		case (apb_req.paddr[11:0])
			`REG_PWM_CTRL: begin
				en  <= apb_req.pwdata[0];
				div <= apb_req.pwdata[15:8];
			end
			`REG_PWM_CC: cc <= apb_req.pwdata[7:0];
			default: ;
		endcase
	end
end

always_comb begin
	case (apb_req.paddr[11:0])
		`REG_PWM_CTRL: apb_resp.prdata = {16'h0, div, 7'h0, en};
		`REG_PWM_CC:   apb_resp.prdata = {24'h0, cc};
		default:       apb_resp.prdata = '0;
	endcase
end

assign apb_resp.pready  = 1'b1;
assign apb_resp.pslverr = 1'b0;

// ========================================
// Counter
// ========================================

assign div_m1     = (div == 8'd0) ? 8'd0 : div - 8'd1;
assign presc_wrap = presc >= div_m1; // >= copes with div shrinking mid-count

always_ff @(posedge clk) begin
	if (reset || !en) begin
		presc <= 8'd0;
		ctr   <= 8'd0;
	end else if (presc_wrap) begin
		presc <= 8'd0;
		ctr   <= ctr + 8'd1; // Wraps every 256 ticks
	end else begin
		presc <= presc + 8'd1;
	end
end

assign pwm_out = en && ctr < cc;

endmodule
